/* verification/gear_stimulus.txt */
# operand A, operand B, expected correction count
# all columns in hex, one pair per line
00000 00000 0
00001 00002 0
12345 0ABCD 0
FFFFF 00000 0
55555 AAAAA 0
07FE0 00000 0
00200 00200 0
003FF 00001 1
003E0 00020 1
003FF 003FF 1
07C00 00400 1
07E00 00200 1
0F800 07C00 1
07FFF 00001 2
07FE0 00420 2
3FFFF 00020 2
FFFFF 00001 2
FFFFF FFFFF 2

/* flist.f */
+incdir+include
design/gear_pkg.sv
design/gear_stage_if.sv
design/gear_wb_port.sv
design/gear_recovery_adder.sv
design/gear_result_buffer.sv
design/gear_adder_top.sv
verification/tb_gear_adder.sv

/* Makefile */
TOP = tb_gear_adder

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

/* verification/tb_gear_adder.sv */
`timescale 1ns/1ps
`include "gear_cfg.svh"

module tb_gear_adder;
	import gear_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int W            = `GEAR_WIDTH;
	localparam int SUBS         = (`GEAR_WIDTH - `GEAR_P) / `GEAR_R;
	localparam int LCG_PAIRS    = 40;
	localparam int MAX_DIRECTED = 32;
	// Bus cycles allowed for one write, poll and read sequence
	localparam int OP_CYCLES    = 30;
	localparam int TIMEOUT_NS   = (MAX_DIRECTED + LCG_PAIRS + 16) * OP_CYCLES * CLK_PERIOD;
	localparam int POLL_LIMIT   = 50;

	logic        clk;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	wb_addr_t    wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	int          errors;
	int          checks;
	logic [31:0] lcg_state;
	operand_t    dir_a[$];
	operand_t    dir_b[$];
	int          dir_corr[$];

	gear_adder_top dut0 (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns with the test still running", TIMEOUT_NS);
		$display("Done: errors found");
		$finish;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Window fully propagating and a true carry arriving at its top
	function automatic int expected_corr(input operand_t a, input operand_t b);
		int         cnt;
		int         base;
		int         top;
		logic [W:0] low_sum;
		operand_t   below;
		operand_t   win_mask;
		cnt = 0;
		for (int j = 1; j < SUBS; j++)
		begin
			base     = j * `GEAR_R;
			top      = base + `GEAR_P;
			below    = operand_t'((1 << top) - 1);
			win_mask = operand_t'(((1 << `GEAR_P) - 1) << base);
			low_sum  = {1'b0, a & below} + {1'b0, b & below};
			if ((((a | b) & win_mask) == win_mask) && low_sum[top])
				cnt++;
		end
		return cnt;
	endfunction

	//////////////////////////////
	// Bus access
	//////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("[FAIL] %0d ns: %s expected %h, got %h", $time, name, expected, actual);
	endtask

	task automatic bus_write(input wb_addr_t adr, input logic [31:0] data);
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = data;
		do @(negedge clk); while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_read(input wb_addr_t adr, output logic [31:0] data);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		do @(negedge clk); while (!wb_ack);
		data   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// Idle adder or a non-empty queue, depending on for_idle
	task automatic poll_status(input bit for_idle, input string what);
		logic [31:0] status;
		bit          met;
		int          polls;
		met   = 1'b0;
		polls = 0;
		while (!met && polls < POLL_LIMIT)
		begin
			bus_read(ADDR_STATUS, status);
			met = for_idle ? (status[3] == 1'b0) : (status[2:0] != 3'd0);
			polls++;
		end
		if (!met)
		begin
			errors++;
			$display("Gave up waiting for %s after %0d status reads", what, POLL_LIMIT);
		end
	endtask

	task automatic check_next_result(input sum_t exp_sum, input int exp_corr);
		logic [31:0] word;
		bus_read(ADDR_RESULT, word);
		checks++;
		if (word[31] !== 1'b1)
			report_mismatch("result valid", 32'd1, 32'(word[31]));
		if (word[23:22] !== 2'(exp_corr))
			report_mismatch("corr_cnt", 32'(exp_corr), 32'(word[23:22]));
		if (word[20:0] !== exp_sum)
			report_mismatch("sum", 32'(exp_sum), 32'(word[20:0]));
	endtask

	task automatic run_pair(input operand_t a, input operand_t b, input int exp_corr);
		bus_write(ADDR_OP_A, 32'(a));
		bus_write(ADDR_OP_B, 32'(b));
		poll_status(1'b0, "a queued result");
		check_next_result(sum_t'(a) + sum_t'(b), exp_corr);
	endtask

	//////////////////////////////
	// Stimulus and test sequences
	//////////////////////////////

	task automatic load_stimulus();
		int          fd;
		string       line;
		logic [31:0] fa;
		logic [31:0] fb;
		logic [31:0] fc;
		fd = $fopen("verification/gear_stimulus.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("Could not open verification/gear_stimulus.txt");
			return;
		end
		while ($fgets(line, fd) > 0)
		begin
			// Skip comments and blank lines
			if (line.len() == 0 || line.getc(0) == "#")
				continue;
			if ($sscanf(line, "%h %h %h", fa, fb, fc) == 3)
			begin
				dir_a.push_back(operand_t'(fa));
				dir_b.push_back(operand_t'(fb));
				dir_corr.push_back(int'(fc));
			end
		end
		$fclose(fd);
		if (dir_a.size() == 0)
		begin
			errors++;
			$display("The stimulus file held no operand lines");
		end
	endtask

	task automatic empty_read_test();
		logic [31:0] word;
		bus_read(ADDR_STATUS, word);
		checks++;
		if (word !== 32'd0)
			report_mismatch("status after reset", 32'd0, word);
		bus_read(ADDR_RESULT, word);
		checks++;
		if (word[31] !== 1'b0)
			report_mismatch("empty result valid", 32'd0, 32'(word[31]));
		bus_read(ADDR_STATUS, word);
		checks++;
		if (word[2:0] !== 3'd0)
			report_mismatch("level after empty read", 32'd0, 32'(word[2:0]));
	endtask

	task automatic backpressure_test();
		logic [31:0] status;
		operand_t    a;
		operand_t    b;
		sum_t        exp_sum[$];
		int          exp_cnt[$];
		bit          stalled;
		a = 20'h0f0f0;
		bus_write(ADDR_OP_A, 32'(a));
		// Four fill the queue and the fifth is held in the adder
		for (int i = 0; i < 6; i++)
		begin
			b = operand_t'(20'h00011 + i * 20'h01100);
			exp_sum.push_back(sum_t'(a) + sum_t'(b));
			exp_cnt.push_back(expected_corr(a, b));
			if (i < 5)
				bus_write(ADDR_OP_B, 32'(b));
		end
		bus_read(ADDR_STATUS, status);
		checks++;
		if (status[3:0] !== 4'hc)
			report_mismatch("status when full", 32'hc, 32'(status[3:0]));

		// Next B write has to wait without ack
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = ADDR_OP_B;
		wb_dat_w = 32'(b);
		stalled  = 1'b1;
		for (int i = 0; i < 10; i++)
		begin
			@(negedge clk);
			if (wb_ack)
				stalled = 1'b0;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		checks++;
		if (!stalled)
		begin
			errors++;
			$display("A B write was acknowledged while the result queue was full");
		end

		check_next_result(exp_sum.pop_front(), exp_cnt.pop_front());
		poll_status(1'b1, "the adder to go idle");
		bus_write(ADDR_OP_B, 32'(b));
		while (exp_sum.size() > 0)
		begin
			poll_status(1'b0, "a queued result");
			check_next_result(exp_sum.pop_front(), exp_cnt.pop_front());
		end
	endtask

	initial
	begin
		operand_t a;
		operand_t b;
		errors    = 0;
		checks    = 0;
		lcg_state = 32'd68;
		reset     = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = ADDR_OP_A;
		wb_dat_w  = 32'd0;
		load_stimulus();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		empty_read_test();
		for (int i = 0; i < dir_a.size(); i++)
			run_pair(dir_a[i], dir_b[i], dir_corr[i]);
		backpressure_test();
		for (int i = 0; i < LCG_PAIRS; i++)
		begin
			lcg_state = lcg_next(lcg_state);
			a         = operand_t'(lcg_state >> 8);
			lcg_state = lcg_next(lcg_state);
			b         = operand_t'(lcg_state >> 8);
			run_pair(a, b, expected_corr(a, b));
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* design/gear_adder_top.sv */
`timescale 1ns/1ps

module gear_adder_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  gear_pkg::wb_addr_t wb_adr,
	input  logic [31:0]        wb_dat_w,
	output logic [31:0]        wb_dat_r,
	output logic               wb_ack
);
	import gear_pkg::*;

	gear_op_if  op_if ();
	gear_res_if res_if ();

	// Queue read side toward the bus port
	logic       buf_pop;
	sum_t       buf_sum;
	corr_cnt_t  buf_corr;
	logic       buf_empty;
	logic [2:0] buf_level;
	logic       adder_busy;

	gear_wb_port u_port (
		.clk        (clk),
		.reset      (reset),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.op         (op_if.src),
		.buf_pop    (buf_pop),
		.buf_sum    (buf_sum),
		.buf_corr   (buf_corr),
		.buf_empty  (buf_empty),
		.buf_level  (buf_level),
		.adder_busy (adder_busy)
	);

	gear_recovery_adder u_adder (
		.clk   (clk),
		.reset (reset),
		.op    (op_if.snk),
		.res   (res_if.src),
		.busy  (adder_busy)
	);

	gear_result_buffer u_buf (
		.clk       (clk),
		.reset     (reset),
		.res       (res_if.snk),
		.pop       (buf_pop),
		.head_sum  (buf_sum),
		.head_corr (buf_corr),
		.empty     (buf_empty),
		.level     (buf_level)
	);

endmodule

/* design/gear_result_buffer.sv */
`timescale 1ns/1ps
`include "gear_cfg.svh"

module gear_result_buffer (
	input  logic                clk,
	input  logic                reset,
	gear_res_if.snk             res,
	input  logic                pop,
	output gear_pkg::sum_t      head_sum,
	output gear_pkg::corr_cnt_t head_corr,
	output logic                empty,
	output logic [2:0]          level
);
	import gear_pkg::*;

	localparam int DEPTH = `GEAR_BUF_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	sum_t       mem_sum  [DEPTH];
	corr_cnt_t  mem_corr [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [2:0] count;
	logic       push;

	assign res.ready = (count != 3'(DEPTH));
	assign push      = res.valid && res.ready;

	assign empty     = (count == 3'd0);
	assign level     = count;
	assign head_sum  = mem_sum[rd_ptr];
	assign head_corr = mem_corr[rd_ptr];

	// Storage
	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem_sum[wr_ptr]  <= res.sum;
			mem_corr[wr_ptr] <= res.corr_cnt;
		end
	end

	//////////////////////////////
	// Pointers and fill level
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leave the level unchanged
			count <= count + 3'(push) - 3'(pop);
		end
	end

	// Port only pops a non-empty queue
	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty);

endmodule

/* design/gear_recovery_adder.sv */
`timescale 1ns/1ps
`include "gear_cfg.svh"

module gear_recovery_adder (
	input  logic    clk,
	input  logic    reset,
	gear_op_if.snk  op,
	gear_res_if.src res,
	output logic    busy
);
	import gear_pkg::*;

	localparam int N    = `GEAR_WIDTH;
	localparam int R    = `GEAR_R;
	localparam int P    = `GEAR_P;
	localparam int L    = R + P;
	localparam int SUBS = (N - P) / R;

	operand_t          a_q;
	operand_t          b_q;
	logic [SUBS-2:0]   corr_q;
	logic [L-1:0]      sub_sum [SUBS];
	wire  [SUBS-1:0]   sub_co;
	wire  [SUBS-2:0]   flag;
	logic [SUBS-2:0]   new_flag;
	sum_t              sum_w;

	if (N != P + R * SUBS)
	begin : g_cfg_check
		$error("GEAR_WIDTH must equal GEAR_P plus GEAR_R times the sub-adder count");
	end

	//////////////////////////////
	// Sub-adders
	//////////////////////////////

	genvar j;
	generate
		for (j = 0; j < SUBS; j++)
		begin : g_sub
			if (j == 0)
			begin : g_low
				// Lowest sub-adder sees the true carry chain
				assign {sub_co[0], sub_sum[0]} = a_q[L-1:0] + b_q[L-1:0];
			end
			else
			begin : g_high
				localparam int BASE = j * R;
				logic [L-1:0] a_in;
				logic [L-1:0] b_in;
				logic         win_prop;

				// Forced generate at the window base once an error was seen
				assign a_in = {a_q[BASE+L-1:BASE+1], a_q[BASE] | corr_q[j-1]};
				assign b_in = {b_q[BASE+L-1:BASE+1], b_q[BASE] | corr_q[j-1]};
				assign {sub_co[j], sub_sum[j]} = a_in + b_in;

				// Whole window can pass a carry and one arrives from below
				assign win_prop  = &(a_q[BASE+P-1:BASE] | b_q[BASE+P-1:BASE]);
				assign flag[j-1] = win_prop & sub_co[j-1];
			end
		end
	endgenerate

	// Low sub-adder fully, then the upper R bits of each higher one
	always_comb
	begin
		sum_w = '0;
		sum_w[L-1:0] = sub_sum[0];
		for (int k = 1; k < SUBS; k++)
			sum_w[k*R + P +: R] = sub_sum[k][L-1 -: R];
		sum_w[N] = sub_co[SUBS-1];
	end

	assign new_flag = flag & ~corr_q;

	assign op.ready     = !busy;
	assign res.valid    = busy && !(|new_flag);
	assign res.sum      = sum_w;
	assign res.corr_cnt = corr_cnt_t'($countones(corr_q));

	//////////////////////////////
	// Control and recovery
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (op.valid && op.ready)
		begin
			a_q <= op.a;
			b_q <= op.b;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy   <= 1'b0;
			corr_q <= '0;
		end
		else if (op.valid && op.ready)
		begin
			busy   <= 1'b1;
			corr_q <= '0;
		end
		else if (res.valid && res.ready)
			busy <= 1'b0;
		else if (busy)
			corr_q <= corr_q | flag;
	end

	// Corrections only accumulate within one addition
	a_corr_sticky: assert property (@(posedge clk) disable iff (reset)
		busy |=> ((corr_q & $past(corr_q)) == $past(corr_q)));

	// Held result must not move under back-pressure
	a_sum_hold: assert property (@(posedge clk) disable iff (reset)
		(res.valid && !res.ready) |=> (res.valid && $stable(res.sum)));

endmodule

/* design/gear_wb_port.sv */
`timescale 1ns/1ps

module gear_wb_port (
	input  logic               clk,
	input  logic               reset,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  gear_pkg::wb_addr_t wb_adr,
	input  logic [31:0]        wb_dat_w,
	output logic [31:0]        wb_dat_r,
	output logic               wb_ack,
	gear_op_if.src             op,
	output logic               buf_pop,
	input  gear_pkg::sum_t     buf_sum,
	input  gear_pkg::corr_cnt_t buf_corr,
	input  logic               buf_empty,
	input  logic [2:0]         buf_level,
	input  logic               adder_busy
);
	import gear_pkg::*;

	operand_t op_a_q;
	logic     held_q;
	logic     req;
	logic     wr_b;
	logic     rd_res;
	logic     done;

	// New bus cycle only after the previous one has dropped stb
	assign req    = wb_cyc && wb_stb && !held_q;
	assign wr_b   = req && wb_we && (wb_adr == ADDR_OP_B);
	assign rd_res = req && !wb_we && (wb_adr == ADDR_RESULT);

	// B write completes only when the adder takes the pair
	assign done = req && (!wr_b || op.ready);

	assign op.valid = wr_b;
	assign op.a     = op_a_q;
	assign op.b     = wb_dat_w[$bits(operand_t)-1:0];

	assign buf_pop = rd_res && !buf_empty;

	//////////////////////////////
	// Bus handshake
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wb_ack <= 1'b0;
			held_q <= 1'b0;
		end
		else
		begin
			wb_ack <= done;
			if (done)
				held_q <= 1'b1;
			else if (!(wb_cyc && wb_stb))
				held_q <= 1'b0;
		end
	end

	//////////////////////////////
	// Registers and read data
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (req && wb_we && (wb_adr == ADDR_OP_A))
			op_a_q <= wb_dat_w[$bits(operand_t)-1:0];

		if (req && !wb_we)
		begin
			case (wb_adr)
				ADDR_OP_A:   wb_dat_r <= 32'(op_a_q);
				// Valid bit low when nothing is queued
				ADDR_RESULT: wb_dat_r <= {!buf_empty, 7'b0, buf_corr, 1'b0, buf_sum};
				ADDR_STATUS: wb_dat_r <= {28'b0, adder_busy, buf_level};
				default:     wb_dat_r <= '0;
			endcase
		end
	end

	// Single-cycle ack per bus cycle
	a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack);

endmodule

/* design/gear_stage_if.sv */
`timescale 1ns/1ps

// Operand pair from the bus port into the adder stage
interface gear_op_if;
	import gear_pkg::*;

	logic     valid;
	logic     ready;
	operand_t a;
	operand_t b;

	modport src (output valid, output a, output b, input ready);

	modport snk (input valid, input a, input b, output ready);
endinterface

// Finished sum from the adder stage into the result queue
interface gear_res_if;
	import gear_pkg::*;

	logic      valid;
	logic      ready;
	sum_t      sum;
	corr_cnt_t corr_cnt;

	modport src (output valid, output sum, output corr_cnt, input ready);

	modport snk (input valid, input sum, input corr_cnt, output ready);
endinterface

/* design/gear_pkg.sv */
`include "gear_cfg.svh"

package gear_pkg;

	//////////////////////////////
	// Data types
	//////////////////////////////

	// One addend
	typedef logic [`GEAR_WIDTH-1:0] operand_t;

	// Exact sum including the final carry
	typedef logic [`GEAR_WIDTH:0] sum_t;

	// Number of sub-adders that went through recovery
	typedef logic [1:0] corr_cnt_t;

	// Word address on the bus
	typedef logic [1:0] wb_addr_t;

	//////////////////////////////
	// Register map
	//////////////////////////////

	localparam wb_addr_t ADDR_OP_A   = 2'd0;
	// Writing B also launches the addition
	localparam wb_addr_t ADDR_OP_B   = 2'd1;
	// Reading pops the oldest result
	localparam wb_addr_t ADDR_RESULT = 2'd2;
	localparam wb_addr_t ADDR_STATUS = 2'd3;

endpackage

/* include/gear_cfg.svh */
`ifndef GEAR_CFG_SVH
`define GEAR_CFG_SVH

//////////////////////////////
// Adder geometry
//////////////////////////////

// Operand width in bits
`define GEAR_WIDTH 20

// Result bits taken from each sub-adder above the lowest
`define GEAR_R 5

// Carry prediction window below each result part
`define GEAR_P 5

// Result queue depth
`define GEAR_BUF_DEPTH 4

`endif
